// File: common/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // operation select for the integer arithmetic unit
    typedef enum logic [1:0] {
        XARITH_ADD    = 2'd0,
        XARITH_SLT    = 2'd1,
        XARITH_BRANCH = 2'd2,
        XARITH_PC     = 2'd3
    } xarith_op_e;

    // operation select for the integer logic unit
    typedef enum logic [2:0] {
        XLOGIC_AND  = 3'd0,
        XLOGIC_OR   = 3'd1,
        XLOGIC_XOR  = 3'd2,
        XLOGIC_PASS = 3'd3,
        XLOGIC_CLZ  = 3'd4
    } xlogic_op_e;

    // members are listed from the top bit down so opsel lands in the low bits
    typedef struct packed {
        logic       word;
        logic       branch_invert;
        logic       branch_equal;
        logic       branch_en;
        logic       cmp_mode;
        logic       is_unsigned;
        logic       sub;
        xarith_op_e opsel;
    } xarith_fields_t;

    typedef struct packed {
        logic       word;
        logic [1:0] sll;
        logic       invert;
        xlogic_op_e opsel;
    } xlogic_fields_t;

    // banksel picks the (rs1, rs2) read pair when low and (rs3, rs4) when high
    typedef struct packed {
        logic           banksel;
        logic           op1_sel;
        logic           op2_sel;
        logic           rd_wen;
        logic [63:0]    imm;
        logic [63:0]    pc_rdata;
        logic [63:0]    pc_wdata;
        xarith_fields_t fields;
        logic [4:0]     rd;
    } xarith_ctrl_t;

    // op1 of the logic unit is always rs1, so it carries no op1 select
    typedef struct packed {
        logic           banksel;
        logic           op2_sel;
        logic           rd_wen;
        logic [63:0]    imm;
        xlogic_fields_t fields;
        logic [4:0]     rd;
    } xlogic_ctrl_t;

endpackage

`default_nettype wire

// File: common/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int unsigned XLEN     = 64;
    localparam int unsigned NUM_REGS = 32;
    localparam int unsigned REG_AW   = 5;
    localparam int unsigned IMM_W    = 32;

    typedef logic [REG_AW-1:0]   reg_addr_t;
    typedef logic [NUM_REGS-1:0] reg_mask_t;

    // execution unit that a bundle is sent to
    typedef enum logic {
        PIPE_XARITH = 1'b0,
        PIPE_XLOGIC = 1'b1
    } pipe_e;

    // op2_sel high means op2 comes from the immediate and rs2 is not read
    typedef struct packed {
        logic rd_wen;
        logic op2_sel;
        logic op1_sel;
    } shared_ctrl_t;

    // bundle as delivered by decode with rs1 in the lowest bits
    typedef struct packed {
        logic [XLEN-1:0]          pc_wdata;
        logic [XLEN-1:0]          pc_rdata;
        exec_pkg::xlogic_fields_t xlogic;
        exec_pkg::xarith_fields_t xarith;
        shared_ctrl_t             shared;
        pipe_e                    pipe;
        logic [IMM_W-1:0]         imm32;
        reg_addr_t                rd;
        reg_addr_t                rs2;
        reg_addr_t                rs1;
    } issue_bundle_t;

    // one bundle after decode with the immediate widened to XLEN
    typedef struct packed {
        pipe_e                    pipe;
        reg_addr_t                rd;
        logic [XLEN-1:0]          imm;
        shared_ctrl_t             shared;
        exec_pkg::xarith_fields_t xarith;
        exec_pkg::xlogic_fields_t xlogic;
        logic [XLEN-1:0]          pc_rdata;
        logic [XLEN-1:0]          pc_wdata;
    } decoded_bundle_t;

endpackage

`default_nettype wire

// File: issue/bundle_decode.sv
`timescale 1ns/10ps
`default_nettype none

module bundle_decode (
    input  issue_pkg::issue_bundle_t   i_bundle,
    output issue_pkg::decoded_bundle_t o_decoded,
    output issue_pkg::reg_mask_t       o_hazard_mask,
    output issue_pkg::reg_mask_t       o_rd_mask
);

    localparam int unsigned EXT_W = issue_pkg::XLEN - issue_pkg::IMM_W;

    issue_pkg::reg_mask_t rs1_onehot;
    issue_pkg::reg_mask_t rs2_onehot;
    issue_pkg::reg_mask_t rd_onehot;
    logic [EXT_W-1:0]     imm_ext;

    // the encoded immediate is at most 32 bits and is widened with its sign bit
    assign imm_ext = {EXT_W{i_bundle.imm32[issue_pkg::IMM_W-1]}};

    always_comb begin
        o_decoded.pipe     = i_bundle.pipe;
        o_decoded.rd       = i_bundle.rd;
        o_decoded.imm      = {imm_ext, i_bundle.imm32};
        o_decoded.shared   = i_bundle.shared;
        o_decoded.xarith   = i_bundle.xarith;
        o_decoded.xlogic   = i_bundle.xlogic;
        o_decoded.pc_rdata = i_bundle.pc_rdata;
        o_decoded.pc_wdata = i_bundle.pc_wdata;
    end

    assign rs1_onehot = issue_pkg::reg_mask_t'(1) << i_bundle.rs1;
    assign rd_onehot  = issue_pkg::reg_mask_t'(1) << i_bundle.rd;

    // rs2 is not read at all when op2 is taken from the immediate
    assign rs2_onehot = (issue_pkg::reg_mask_t'(1) << i_bundle.rs2)
                      & {issue_pkg::NUM_REGS{!i_bundle.shared.op2_sel}};

    // a bundle waits on its sources (RAW) and on its destination (WAW)
    assign o_hazard_mask = rs1_onehot | rs2_onehot | rd_onehot;

    // x0 is hardwired to zero and must never be reserved
    assign o_rd_mask = rd_onehot & ~issue_pkg::reg_mask_t'(1);

endmodule

`default_nettype wire

// File: issue/reservation_table.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_table (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  issue_pkg::reg_mask_t i_hazard_mask0,
    input  issue_pkg::reg_mask_t i_hazard_mask1,
    input  issue_pkg::reg_mask_t i_rd_mask0,
    input  issue_pkg::reg_mask_t i_rd_mask1,
    input  wire                  i_transmit0,
    input  wire                  i_transmit1,
    input  issue_pkg::reg_mask_t i_retire0,
    input  issue_pkg::reg_mask_t i_retire1,
    output logic                 o_clear0,
    output logic                 o_clear1
);

    // one bit per register whose write is still in flight
    issue_pkg::reg_mask_t reservation_q;
    issue_pkg::reg_mask_t reservation_d;
    issue_pkg::reg_mask_t retire;
    issue_pkg::reg_mask_t reserve;

    assign retire = i_retire0 | i_retire1;

    // destinations of the bundles leaving this cycle become reserved
    assign reserve = (i_rd_mask0 & {issue_pkg::NUM_REGS{i_transmit0}})
                   | (i_rd_mask1 & {issue_pkg::NUM_REGS{i_transmit1}});

    // a retire and a new reservation of the same register in one cycle
    // leaves the register reserved for the newer instruction
    assign reservation_d = (reservation_q & ~retire) | reserve;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reservation_q <= '0;
        end else begin
            reservation_q <= reservation_d;
        end
    end

    // WAR cannot happen here since reads happen strictly before writes
    // and dispatch is in order, so only RAW and WAW are checked
    assign o_clear0 = (reservation_q & i_hazard_mask0) == '0;
    assign o_clear1 = (reservation_q & i_hazard_mask1) == '0;

endmodule

`default_nettype wire

// File: issue/dispatch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_ctrl (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    input  wire                  i_input_valid,
    input  issue_pkg::pipe_e     i_pipe0,
    input  issue_pkg::pipe_e     i_pipe1,
    input  issue_pkg::reg_addr_t i_rd0,
    input  issue_pkg::reg_addr_t i_rd1,
    input  wire                  i_clear0,
    input  wire                  i_clear1,
    input  wire                  i_xarith_ready,
    input  wire                  i_xlogic_ready,
    output logic                 o_transmit0,
    output logic                 o_transmit1,
    output logic                 o_xarith_fire,
    output logic                 o_xlogic_fire,
    output logic                 o_xarith_src1,
    output logic                 o_xlogic_src1,
    output logic                 o_input_ready
);

    // tracks whether bundle 0 of the current pair has already left
    typedef enum logic {
        PAIR_OPEN    = 1'b0,
        PAIR_B0_DONE = 1'b1
    } pair_state_e;

    pair_state_e state_q;
    pair_state_e state_d;
    logic        b0_done;
    logic        b0_dispatch;
    logic        b1_dispatch;
    logic        b0_unit_ready;
    logic        b1_unit_ready;
    logic        pair_ok;
    logic        b0_to_xarith;
    logic        b1_to_xarith;

    assign b0_done = (state_q == PAIR_B0_DONE);

    assign b0_to_xarith = (i_pipe0 == issue_pkg::PIPE_XARITH);
    assign b1_to_xarith = (i_pipe1 == issue_pkg::PIPE_XARITH);

    assign b0_unit_ready = b0_to_xarith ? i_xarith_ready : i_xlogic_ready;
    assign b1_unit_ready = b1_to_xarith ? i_xarith_ready : i_xlogic_ready;

    // bundle 0 goes once its operands and destination are free
    assign b0_dispatch = i_input_valid && !b0_done && i_clear0;
    assign o_transmit0 = b0_dispatch && b0_unit_ready;

    // while bundle 0 is still here, bundle 1 may only go alongside it if
    // the two use different units and write different registers
    // once bundle 0 has left, its rd is in the scoreboard and covers WAW
    assign pair_ok = b0_done || ((i_rd0 != i_rd1) && (i_pipe0 != i_pipe1));

    // bundle 1 never overtakes bundle 0
    assign b1_dispatch = i_input_valid && i_clear1 && pair_ok
                      && (o_transmit0 || b0_done);
    assign o_transmit1 = b1_dispatch && b1_unit_ready;

    // both bundles never reach the same unit in one cycle
    assign o_xarith_fire = (o_transmit0 && b0_to_xarith) || (o_transmit1 && b1_to_xarith);
    assign o_xlogic_fire = (o_transmit0 && !b0_to_xarith) || (o_transmit1 && !b1_to_xarith);

    assign o_xarith_src1 = o_transmit1 && b1_to_xarith;
    assign o_xlogic_src1 = o_transmit1 && !b1_to_xarith;

    // the pair is consumed when its second bundle leaves
    assign o_input_ready = o_transmit1;

    always_comb begin
        state_d = state_q;
        if (o_transmit1) begin
            state_d = PAIR_OPEN;
        end else if (o_transmit0) begin
            state_d = PAIR_B0_DONE;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= PAIR_OPEN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: issue/xarith_port.sv
`timescale 1ns/10ps
`default_nettype none

module xarith_port (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  issue_pkg::decoded_bundle_t i_bundle0,
    input  issue_pkg::decoded_bundle_t i_bundle1,
    input  wire                        i_transmit,
    input  wire                        i_src1,
    output exec_pkg::xarith_ctrl_t     o_ctrl,
    output logic                       o_valid
);

    issue_pkg::decoded_bundle_t sel;
    exec_pkg::xarith_ctrl_t     ctrl_d;

    assign sel = i_src1 ? i_bundle1 : i_bundle0;

    // banksel points the unit at the read pair of the bundle it received
    always_comb begin
        ctrl_d.banksel  = i_src1;
        ctrl_d.op1_sel  = sel.shared.op1_sel;
        ctrl_d.op2_sel  = sel.shared.op2_sel;
        ctrl_d.rd_wen   = sel.shared.rd_wen;
        ctrl_d.imm      = sel.imm;
        ctrl_d.pc_rdata = sel.pc_rdata;
        ctrl_d.pc_wdata = sel.pc_wdata;
        ctrl_d.fields   = sel.xarith;
        ctrl_d.rd       = sel.rd;
    end

    // the control word holds the last bundle sent to this unit
    always_ff @(posedge i_clk) begin
        if (i_transmit) begin
            o_ctrl <= ctrl_d;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_transmit;
        end
    end

endmodule

`default_nettype wire

// File: issue/xlogic_port.sv
`timescale 1ns/10ps
`default_nettype none

module xlogic_port (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  issue_pkg::decoded_bundle_t i_bundle0,
    input  issue_pkg::decoded_bundle_t i_bundle1,
    input  wire                        i_transmit,
    input  wire                        i_src1,
    output exec_pkg::xlogic_ctrl_t     o_ctrl,
    output logic                       o_valid
);

    issue_pkg::decoded_bundle_t sel;
    exec_pkg::xlogic_ctrl_t     ctrl_d;

    assign sel = i_src1 ? i_bundle1 : i_bundle0;

    // the logic unit takes op1 from rs1 and has no use for the PCs
    always_comb begin
        ctrl_d.banksel = i_src1;
        ctrl_d.op2_sel = sel.shared.op2_sel;
        ctrl_d.rd_wen  = sel.shared.rd_wen;
        ctrl_d.imm     = sel.imm;
        ctrl_d.fields  = sel.xlogic;
        ctrl_d.rd      = sel.rd;
    end

    always_ff @(posedge i_clk) begin
        if (i_transmit) begin
            o_ctrl <= ctrl_d;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_transmit;
        end
    end

endmodule

`default_nettype wire

// File: verilog/warp_issue.sv
`timescale 1ns/10ps
`default_nettype none

module warp_issue (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    // pair of bundles from decode, held until o_input_ready
    input  wire                             i_input_valid,
    input  issue_pkg::issue_bundle_t        i_bundle0,
    input  issue_pkg::issue_bundle_t        i_bundle1,
    output logic                            o_input_ready,
    // register file read addresses, bundle 0 rs1/rs2 then bundle 1 rs1/rs2
    output issue_pkg::reg_addr_t [3:0]      o_rs_addr,
    // integer arithmetic unit
    output exec_pkg::xarith_ctrl_t          o_xarith_ctrl,
    output logic                            o_xarith_valid,
    input  wire                             i_xarith_ready,
    // integer logic unit
    output exec_pkg::xlogic_ctrl_t          o_xlogic_ctrl,
    output logic                            o_xlogic_valid,
    input  wire                             i_xlogic_ready,
    // registers released by the units as their instructions retire
    input  issue_pkg::reg_mask_t            i_inst0_retire,
    input  issue_pkg::reg_mask_t            i_inst1_retire
);

    issue_pkg::decoded_bundle_t dec0;
    issue_pkg::decoded_bundle_t dec1;
    issue_pkg::reg_mask_t       hazard_mask0;
    issue_pkg::reg_mask_t       hazard_mask1;
    issue_pkg::reg_mask_t       rd_mask0;
    issue_pkg::reg_mask_t       rd_mask1;
    logic                       clear0;
    logic                       clear1;
    logic                       transmit0;
    logic                       transmit1;
    logic                       xarith_fire;
    logic                       xlogic_fire;
    logic                       xarith_src1;
    logic                       xlogic_src1;

    // reads are presented straight from the pair so data is there on dispatch
    assign o_rs_addr[0] = i_bundle0.rs1;
    assign o_rs_addr[1] = i_bundle0.rs2;
    assign o_rs_addr[2] = i_bundle1.rs1;
    assign o_rs_addr[3] = i_bundle1.rs2;

    bundle_decode u_decode0 (
        .i_bundle      (i_bundle0),
        .o_decoded     (dec0),
        .o_hazard_mask (hazard_mask0),
        .o_rd_mask     (rd_mask0)
    );

    bundle_decode u_decode1 (
        .i_bundle      (i_bundle1),
        .o_decoded     (dec1),
        .o_hazard_mask (hazard_mask1),
        .o_rd_mask     (rd_mask1)
    );

    reservation_table u_reservation (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_hazard_mask0 (hazard_mask0),
        .i_hazard_mask1 (hazard_mask1),
        .i_rd_mask0     (rd_mask0),
        .i_rd_mask1     (rd_mask1),
        .i_transmit0    (transmit0),
        .i_transmit1    (transmit1),
        .i_retire0      (i_inst0_retire),
        .i_retire1      (i_inst1_retire),
        .o_clear0       (clear0),
        .o_clear1       (clear1)
    );

    dispatch_ctrl u_dispatch (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .i_pipe0        (dec0.pipe),
        .i_pipe1        (dec1.pipe),
        .i_rd0          (dec0.rd),
        .i_rd1          (dec1.rd),
        .i_clear0       (clear0),
        .i_clear1       (clear1),
        .i_xarith_ready (i_xarith_ready),
        .i_xlogic_ready (i_xlogic_ready),
        .o_transmit0    (transmit0),
        .o_transmit1    (transmit1),
        .o_xarith_fire  (xarith_fire),
        .o_xlogic_fire  (xlogic_fire),
        .o_xarith_src1  (xarith_src1),
        .o_xlogic_src1  (xlogic_src1),
        .o_input_ready  (o_input_ready)
    );

    xarith_port u_xarith_port (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bundle0  (dec0),
        .i_bundle1  (dec1),
        .i_transmit (xarith_fire),
        .i_src1     (xarith_src1),
        .o_ctrl     (o_xarith_ctrl),
        .o_valid    (o_xarith_valid)
    );

    xlogic_port u_xlogic_port (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bundle0  (dec0),
        .i_bundle1  (dec1),
        .i_transmit (xlogic_fire),
        .i_src1     (xlogic_src1),
        .o_ctrl     (o_xlogic_ctrl),
        .o_valid    (o_xlogic_valid)
    );

endmodule

`default_nettype wire

// File: verification/tb_warp_issue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_warp_issue;

    // five tests of up to about 400 cycles each plus margin
    localparam int unsigned TIMEOUT_CYCLES = 3000;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_input_valid;
    issue_pkg::issue_bundle_t   i_bundle0;
    issue_pkg::issue_bundle_t   i_bundle1;
    logic                       i_xarith_ready = 1'b1;
    logic                       i_xlogic_ready = 1'b1;
    issue_pkg::reg_mask_t       i_inst0_retire = '0;
    issue_pkg::reg_mask_t       i_inst1_retire;
    logic                       o_input_ready;
    issue_pkg::reg_addr_t [3:0] o_rs_addr;
    exec_pkg::xarith_ctrl_t     o_xarith_ctrl;
    logic                       o_xarith_valid;
    exec_pkg::xlogic_ctrl_t     o_xlogic_ctrl;
    logic                       o_xlogic_valid;

    // reference state of the scoreboard and the dispatch order
    issue_pkg::reg_mask_t       model_resv;
    logic                       model_b0_done;
    logic                       exp_xarith_valid;
    logic                       exp_xlogic_valid;
    exec_pkg::xarith_ctrl_t     exp_xarith_ctrl;
    exec_pkg::xlogic_ctrl_t     exp_xlogic_ctrl;

    int unsigned                error_count = 0;
    int unsigned                pair_count = 0;
    int unsigned                cycle_count = 0;
    logic                       random_ready = 1'b0;
    logic                       auto_retire = 1'b0;

    warp_issue i_dut (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .i_bundle0      (i_bundle0),
        .i_bundle1      (i_bundle1),
        .o_input_ready  (o_input_ready),
        .o_rs_addr      (o_rs_addr),
        .o_xarith_ctrl  (o_xarith_ctrl),
        .o_xarith_valid (o_xarith_valid),
        .i_xarith_ready (i_xarith_ready),
        .o_xlogic_ctrl  (o_xlogic_ctrl),
        .o_xlogic_valid (o_xlogic_valid),
        .i_xlogic_ready (i_xlogic_ready),
        .i_inst0_retire (i_inst0_retire),
        .i_inst1_retire (i_inst1_retire)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d errors, a pair was never acknowledged",
                     cycle_count, error_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // unit back-pressure and background retirement of reserved registers
    always @(posedge i_clk) begin
        if (random_ready) begin
            i_xarith_ready <= ($urandom % 4) != 0;
            i_xlogic_ready <= ($urandom % 4) != 0;
        end else begin
            i_xarith_ready <= 1'b1;
            i_xlogic_ready <= 1'b1;
        end
        if (auto_retire) begin
            i_inst0_retire <= model_resv & $urandom;
        end else begin
            i_inst0_retire <= '0;
        end
    end

    function automatic issue_pkg::reg_mask_t reg_bit(input issue_pkg::reg_addr_t r);
        return issue_pkg::reg_mask_t'(1) << r;
    endfunction

    function automatic issue_pkg::reg_mask_t hazard_mask(input issue_pkg::issue_bundle_t b);
        issue_pkg::reg_mask_t m;
        m = reg_bit(b.rs1) | reg_bit(b.rd);
        if (!b.shared.op2_sel) begin
            m = m | reg_bit(b.rs2);
        end
        return m;
    endfunction

    function automatic exec_pkg::xarith_ctrl_t expected_xarith(
        input issue_pkg::issue_bundle_t b,
        input logic                     src1
    );
        exec_pkg::xarith_ctrl_t c;
        c.banksel  = src1;
        c.op1_sel  = b.shared.op1_sel;
        c.op2_sel  = b.shared.op2_sel;
        c.rd_wen   = b.shared.rd_wen;
        c.imm      = {{32{b.imm32[31]}}, b.imm32};
        c.pc_rdata = b.pc_rdata;
        c.pc_wdata = b.pc_wdata;
        c.fields   = b.xarith;
        c.rd       = b.rd;
        return c;
    endfunction

    function automatic exec_pkg::xlogic_ctrl_t expected_xlogic(
        input issue_pkg::issue_bundle_t b,
        input logic                     src1
    );
        exec_pkg::xlogic_ctrl_t c;
        c.banksel = src1;
        c.op2_sel = b.shared.op2_sel;
        c.rd_wen  = b.shared.rd_wen;
        c.imm     = {{32{b.imm32[31]}}, b.imm32};
        c.fields  = b.xlogic;
        c.rd      = b.rd;
        return c;
    endfunction

    // register fields are given and the unit fields and PCs are random
    function automatic issue_pkg::issue_bundle_t make_bundle(
        input issue_pkg::pipe_e pipe,
        input int unsigned      rs1,
        input int unsigned      rs2,
        input int unsigned      rd,
        input logic             op2_sel,
        input logic [31:0]      imm32
    );
        issue_pkg::issue_bundle_t b;
        b.rs1            = issue_pkg::reg_addr_t'(rs1);
        b.rs2            = issue_pkg::reg_addr_t'(rs2);
        b.rd             = issue_pkg::reg_addr_t'(rd);
        b.imm32          = imm32;
        b.pipe           = pipe;
        b.shared.op1_sel = ($urandom % 2) != 0;
        b.shared.op2_sel = op2_sel;
        b.shared.rd_wen  = ($urandom % 2) != 0;
        b.xarith         = exec_pkg::xarith_fields_t'(9'($urandom));
        b.xlogic         = exec_pkg::xlogic_fields_t'(7'($urandom));
        b.pc_rdata       = {$urandom, $urandom};
        b.pc_wdata       = {$urandom, $urandom};
        return b;
    endfunction

    function automatic issue_pkg::issue_bundle_t random_bundle();
        issue_pkg::pipe_e pipe;
        pipe = (($urandom % 2) == 0) ? issue_pkg::PIPE_XARITH : issue_pkg::PIPE_XLOGIC;
        return make_bundle(pipe, $urandom % 8, $urandom % 8, $urandom % 8,
                           ($urandom % 2) != 0, $urandom);
    endfunction

    task automatic report_mismatch(input string name, input string exp_val, input string act_val);
        error_count = error_count + 1;
        $display("** Error at %0t: %s expected %s, got %s", $time, name, exp_val, act_val);
    endtask

    // checks one cycle at the falling edge and then advances the model
    task automatic step_model();
        issue_pkg::reg_mask_t m0;
        issue_pkg::reg_mask_t m1;
        issue_pkg::reg_mask_t reserve;
        issue_pkg::reg_addr_t exp_rs [4];
        logic                 b0_arith;
        logic                 b1_arith;
        logic                 rdy0;
        logic                 rdy1;
        logic                 t0;
        logic                 t1;
        logic                 pair_ok;
        int                   k;

        assert (o_xarith_valid === exp_xarith_valid) else
            report_mismatch("o_xarith_valid", $sformatf("%b", exp_xarith_valid),
                            $sformatf("%b", o_xarith_valid));
        assert (o_xlogic_valid === exp_xlogic_valid) else
            report_mismatch("o_xlogic_valid", $sformatf("%b", exp_xlogic_valid),
                            $sformatf("%b", o_xlogic_valid));
        if (exp_xarith_valid) begin
            assert (o_xarith_ctrl === exp_xarith_ctrl) else
                report_mismatch("o_xarith_ctrl", $sformatf("%h", exp_xarith_ctrl),
                                $sformatf("%h", o_xarith_ctrl));
        end
        if (exp_xlogic_valid) begin
            assert (o_xlogic_ctrl === exp_xlogic_ctrl) else
                report_mismatch("o_xlogic_ctrl", $sformatf("%h", exp_xlogic_ctrl),
                                $sformatf("%h", o_xlogic_ctrl));
        end

        exp_rs[0] = i_bundle0.rs1;
        exp_rs[1] = i_bundle0.rs2;
        exp_rs[2] = i_bundle1.rs1;
        exp_rs[3] = i_bundle1.rs2;
        for (k = 0; k < 4; k++) begin
            assert (o_rs_addr[k] === exp_rs[k]) else
                report_mismatch($sformatf("o_rs_addr[%0d]", k), $sformatf("%0d", exp_rs[k]),
                                $sformatf("%0d", o_rs_addr[k]));
        end

        m0       = hazard_mask(i_bundle0);
        m1       = hazard_mask(i_bundle1);
        b0_arith = (i_bundle0.pipe == issue_pkg::PIPE_XARITH);
        b1_arith = (i_bundle1.pipe == issue_pkg::PIPE_XARITH);
        rdy0     = b0_arith ? i_xarith_ready : i_xlogic_ready;
        rdy1     = b1_arith ? i_xarith_ready : i_xlogic_ready;
        t0 = i_input_valid && !model_b0_done && ((model_resv & m0) == '0) && rdy0;
        pair_ok = model_b0_done
               || ((i_bundle0.rd != i_bundle1.rd) && (i_bundle0.pipe != i_bundle1.pipe));
        t1 = i_input_valid && ((model_resv & m1) == '0) && pair_ok
          && (t0 || model_b0_done) && rdy1;

        assert (o_input_ready === t1) else
            report_mismatch("o_input_ready", $sformatf("%b", t1), $sformatf("%b", o_input_ready));

        exp_xarith_valid = (t0 && b0_arith) || (t1 && b1_arith);
        exp_xlogic_valid = (t0 && !b0_arith) || (t1 && !b1_arith);
        if (t1 && b1_arith) begin
            exp_xarith_ctrl = expected_xarith(i_bundle1, 1'b1);
        end else if (t0 && b0_arith) begin
            exp_xarith_ctrl = expected_xarith(i_bundle0, 1'b0);
        end
        if (t1 && !b1_arith) begin
            exp_xlogic_ctrl = expected_xlogic(i_bundle1, 1'b1);
        end else if (t0 && !b0_arith) begin
            exp_xlogic_ctrl = expected_xlogic(i_bundle0, 1'b0);
        end

        reserve = '0;
        if (t0) begin
            reserve = reserve | reg_bit(i_bundle0.rd);
        end
        if (t1) begin
            reserve = reserve | reg_bit(i_bundle1.rd);
            pair_count = pair_count + 1;
        end
        reserve[0] = 1'b0;
        model_resv = (model_resv & ~(i_inst0_retire | i_inst1_retire)) | reserve;
        if (t1) begin
            model_b0_done = 1'b0;
        end else if (t0) begin
            model_b0_done = 1'b1;
        end
    endtask

    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            model_resv       = '0;
            model_b0_done    = 1'b0;
            exp_xarith_valid = 1'b0;
            exp_xlogic_valid = 1'b0;
        end else begin
            step_model();
        end
    end

    // presents a pair as a level and holds it until the stage consumes it
    task automatic send_pair(
        input issue_pkg::issue_bundle_t b0,
        input issue_pkg::issue_bundle_t b1
    );
        logic acked;
        acked = 1'b0;
        @(posedge i_clk);
        i_input_valid <= 1'b1;
        i_bundle0     <= b0;
        i_bundle1     <= b1;
        while (!acked) begin
            @(negedge i_clk);
            acked = (o_input_ready === 1'b1);
            @(posedge i_clk);
        end
        i_input_valid <= 1'b0;
    endtask

    task automatic pulse_retire(input issue_pkg::reg_mask_t mask);
        @(posedge i_clk);
        i_inst1_retire <= mask;
        @(posedge i_clk);
        i_inst1_retire <= '0;
    endtask

    initial begin
        int n;
        void'($urandom(69557));
        i_clk          = 1'b0;
        i_rst_n        = 1'b0;
        i_input_valid  = 1'b0;
        i_bundle0      = '0;
        i_bundle1      = '0;
        i_inst1_retire = '0;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (3) @(posedge i_clk);

        // one bundle per unit with a negative immediate on bundle 0
        send_pair(make_bundle(issue_pkg::PIPE_XARITH, 2, 3, 1, 1'b0, 32'hffff_f234),
                  make_bundle(issue_pkg::PIPE_XLOGIC, 5, 6, 4, 1'b1, 32'h0000_0567));
        pulse_retire('1);

        // both bundles on the logic unit go one after the other
        send_pair(make_bundle(issue_pkg::PIPE_XLOGIC, 1, 2, 7, 1'b0, 32'h8000_0001),
                  make_bundle(issue_pkg::PIPE_XLOGIC, 3, 4, 8, 1'b1, 32'h7fff_fff0));
        pulse_retire('1);

        // reserve x10 and x11, then read x10 until it retires
        send_pair(make_bundle(issue_pkg::PIPE_XARITH, 1, 2, 10, 1'b0, $urandom),
                  make_bundle(issue_pkg::PIPE_XLOGIC, 3, 4, 11, 1'b0, $urandom));
        fork
            send_pair(make_bundle(issue_pkg::PIPE_XARITH, 10, 1, 15, 1'b0, $urandom),
                      make_bundle(issue_pkg::PIPE_XLOGIC, 2, 3, 16, 1'b0, $urandom));
            begin
                repeat (6) @(posedge i_clk);
                pulse_retire(reg_bit(5'd10));
            end
        join

        // x11 is still reserved but rs2 is unused with an immediate op2
        send_pair(make_bundle(issue_pkg::PIPE_XLOGIC, 1, 11, 12, 1'b1, $urandom),
                  make_bundle(issue_pkg::PIPE_XARITH, 0, 0, 0, 1'b1, $urandom));
        send_pair(make_bundle(issue_pkg::PIPE_XARITH, 0, 0, 0, 1'b0, $urandom),
                  make_bundle(issue_pkg::PIPE_XLOGIC, 0, 0, 0, 1'b0, $urandom));

        // bundle 1 shares rd with bundle 0 and then also waits for x13 to retire
        fork
            send_pair(make_bundle(issue_pkg::PIPE_XARITH, 1, 2, 13, 1'b0, $urandom),
                      make_bundle(issue_pkg::PIPE_XLOGIC, 3, 4, 13, 1'b0, $urandom));
            begin
                repeat (5) @(posedge i_clk);
                pulse_retire(reg_bit(5'd13));
            end
        join
        pulse_retire('1);

        // random pairs over few registers with random unit stalls
        random_ready = 1'b1;
        auto_retire  = 1'b1;
        for (n = 0; n < 40; n++) begin
            send_pair(random_bundle(), random_bundle());
        end
        random_ready = 1'b0;
        auto_retire  = 1'b0;
        pulse_retire('1);
        repeat (4) @(posedge i_clk);

        $display("issued %0d pairs in %0d cycles with %0d errors",
                 pair_count, cycle_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
common/exec_pkg.sv
common/issue_pkg.sv
issue/bundle_decode.sv
issue/reservation_table.sv
issue/dispatch_ctrl.sv
issue/xarith_port.sv
issue/xlogic_port.sv
verilog/warp_issue.sv
verification/tb_warp_issue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the warp_issue testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
BIN=sim_warp_issue

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f project.f --top-module tb_warp_issue \
    --Mdir "$OBJ_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
